// ==== design/bus_pkg.sv ====
// Bus package: link widths, request and response structs, fabric sizing
`default_nettype none

package bus_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned BE_W   = DATA_W / 8;

    // ----------------------------------------
    // Fabric sizing
    // ----------------------------------------
    localparam int unsigned SLICE_DEPTH = 1;    // Stages per top-level slice
    localparam int unsigned RAM_WORDS   = 256;  // Scratch RAM depth in words

    // Single-word request, req is a one-cycle strobe
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // Response, rvalid pulses for one cycle
    typedef struct packed {
        logic              rvalid;
        logic              err;     // Unmapped address only
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/soc_map_pkg.sv ====
// Address map package: region windows, region codes and CLINT register offsets
`default_nettype none

package soc_map_pkg;

    // ----------------------------------------
    // Region windows
    // ----------------------------------------
    localparam logic [bus_pkg::ADDR_W-1:0] ROM_BASE   = 32'h0001_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] ROM_LEN    = 32'h0000_1000;

    localparam logic [bus_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] CLINT_LEN  = 32'h0000_C000;

    // DRAM stand-in, contents alias inside the window
    localparam logic [bus_pkg::ADDR_W-1:0] RAM_BASE   = 32'h8000_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] RAM_LEN    = 32'h0001_0000;

    typedef enum logic [1:0] {
        REG_ROM,
        REG_CLINT,
        REG_RAM,
        REG_NONE
    } region_e;

    // ----------------------------------------
    // CLINT register offsets
    // ----------------------------------------
    localparam logic [15:0] MSIP_OFF     = 16'h0000;
    localparam logic [15:0] MTIMECMP_OFF = 16'h4000;
    localparam logic [15:0] MTIME_OFF    = 16'hBFF8;

endpackage

`default_nettype wire

// ==== design/bus_slice.sv ====
// Register slice: DEPTH pipeline stages for any packed payload
`timescale 1ns/1ps
`default_nettype none

module bus_slice #(
    parameter type         payload_t = logic [31:0],
    parameter int unsigned DEPTH     = 1
) (
    input  logic     clk,
    input  logic     ndmreset_n,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;   // Strobes come out of reset low
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/addr_decoder.sv ====
// Address decoder: steers requests to ROM, CLINT or RAM and merges the responses
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o,
    output bus_pkg::bus_req_t rom_req_o,
    output bus_pkg::bus_req_t clint_req_o,
    output bus_pkg::bus_req_t ram_req_o,
    input  bus_pkg::bus_rsp_t rom_rsp_i,
    input  bus_pkg::bus_rsp_t clint_rsp_i,
    input  bus_pkg::bus_rsp_t ram_rsp_i
);

    import bus_pkg::*;
    import soc_map_pkg::*;

    region_e region_d;
    region_e region_q;
    logic    pend_q;    // A request was issued last cycle

    // ----------------------------------------
    // Region match
    // ----------------------------------------
    // Offset compare wraps below the base, so one test covers both bounds
    always_comb begin
        if (req_i.addr - ROM_BASE < ROM_LEN) begin
            region_d = REG_ROM;
        end else if (req_i.addr - CLINT_BASE < CLINT_LEN) begin
            region_d = REG_CLINT;
        end else if (req_i.addr - RAM_BASE < RAM_LEN) begin
            region_d = REG_RAM;
        end else begin
            region_d = REG_NONE;
        end
    end

    // Fan-out, only the selected target sees req
    always_comb begin
        rom_req_o       = req_i;
        clint_req_o     = req_i;
        ram_req_o       = req_i;
        rom_req_o.req   = req_i.req && (region_d == REG_ROM);
        clint_req_o.req = req_i.req && (region_d == REG_CLINT);
        ram_req_o.req   = req_i.req && (region_d == REG_RAM);
    end

    // ----------------------------------------
    // Response merge
    // ----------------------------------------
    // One stage, targets answer one cycle after req
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            pend_q   <= 1'b0;
            region_q <= REG_NONE;
        end else begin
            pend_q   <= req_i.req;
            region_q <= region_d;
        end
    end

    always_comb begin
        case (region_q)
            REG_ROM:   rsp_o = rom_rsp_i;
            REG_CLINT: rsp_o = clint_rsp_i;
            REG_RAM:   rsp_o = ram_rsp_i;
            default: begin
                rsp_o        = '0;      // Unmapped, zero data
                rsp_o.rvalid = pend_q;
                rsp_o.err    = pend_q;
            end
        endcase
    end

    a_req_onehot: assert property (@(posedge clk) disable iff (!ndmreset_n)
        $onehot0({rom_req_o.req, clint_req_o.req, ram_req_o.req}))
        else $error("addr_decoder: request sent to more than one target");

    // Targets must never answer in the same cycle
    a_rsp_onehot: assert property (@(posedge clk) disable iff (!ndmreset_n)
        $onehot0({rom_rsp_i.rvalid, clint_rsp_i.rvalid, ram_rsp_i.rvalid}))
        else $error("addr_decoder: more than one target response");

endmodule

`default_nettype wire

// ==== design/boot_rom.sv ====
// Boot ROM: eight 64-bit words loaded from a hex image, one-cycle read
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o
);

    import bus_pkg::*;

    logic [DATA_W-1:0] rom_mem [8];
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    initial begin
        $readmemh("design/boot_rom.hex", rom_mem);
    end

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    // Writes are acknowledged with zero data
    always_ff @(posedge clk) begin
        if (req_i.req) begin
            rdata_q <= req_i.we ? '0 : rom_mem[req_i.addr[5:3]];  // Word index
        end
    end

    assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== design/scratch_ram.sv ====
// Scratch RAM: byte-enabled word memory standing in for DRAM, aliased in its window
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o
);

    import bus_pkg::*;

    logic [DATA_W-1:0]            ram_mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] ram_idx;
    logic                         rvalid_q;
    logic [DATA_W-1:0]            rdata_q;

    // Bits 10..3, upper window bits are ignored so the RAM repeats every 2 KiB
    assign ram_idx = req_i.addr[$clog2(BE_W) +: $clog2(RAM_WORDS)];

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.req && req_i.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (req_i.be[b]) begin
                    ram_mem[ram_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
        if (req_i.req) begin
            rdata_q <= req_i.we ? '0 : ram_mem[ram_idx];   // Old word on read
        end
    end

    assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

    a_write_be: assert property (@(posedge clk) disable iff (!ndmreset_n)
        (req_i.req && req_i.we) |-> (req_i.be != '0))
        else $error("scratch_ram: write with no byte enabled");

endmodule

`default_nettype wire

// ==== design/clint_regs.sv ====
// CLINT register block: msip, mtimecmp and mtime readback over the bus
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o,
    input  logic [63:0]       mtime_i,
    output logic [63:0]       mtimecmp_o,
    output logic              ipi_o
);

    import bus_pkg::*;
    import soc_map_pkg::*;

    logic [$bits(MSIP_OFF)-1:0] reg_off;
    logic                       msip_q;
    logic [63:0]                mtimecmp_q;
    logic [DATA_W-1:0]          rd_word;
    logic                       rvalid_q;
    logic [DATA_W-1:0]          rdata_q;

    // Base is 64 KiB aligned so the low bits are the offset, word aligned
    assign reg_off = {req_i.addr[$bits(MSIP_OFF)-1:3], 3'b000};

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= '1;       // No timer interrupt out of reset
        end else if (req_i.req && req_i.we) begin
            if (reg_off == MSIP_OFF && req_i.be[0]) begin
                msip_q <= req_i.wdata[0];
            end
            if (reg_off == MTIMECMP_OFF) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (req_i.be[b]) begin
                        mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Readback
    // ----------------------------------------
    always_comb begin
        case (reg_off)
            MSIP_OFF:     rd_word = {{(DATA_W-1){1'b0}}, msip_q};
            MTIMECMP_OFF: rd_word = mtimecmp_q;
            MTIME_OFF:    rd_word = mtime_i;    // Counter lives in the timer
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.req) begin
            rdata_q <= req_i.we ? '0 : rd_word;
        end
    end

    assign rsp_o      = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
    assign mtimecmp_o = mtimecmp_q;
    assign ipi_o      = msip_q;

endmodule

`default_nettype wire

// ==== design/clint_timer.sv ====
// CLINT timer: rtc at half clock rate, mtime counter and compare interrupt
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  logic        clk,
    input  logic        ndmreset_n,
    input  logic [63:0] mtimecmp_i,
    output logic [63:0] mtime_o,
    output logic        timer_irq_o
);

    logic        rtc_q;
    logic [63:0] mtime_q;
    logic        irq_q;

    // Clock divided by two
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q <= 1'b0;
        end else begin
            rtc_q <= ~rtc_q;
        end
    end

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (rtc_q) begin
                mtime_q <= mtime_q + 64'd1;     // One tick every second cycle
            end
            irq_q <= (mtime_q >= mtimecmp_i);   // Level, held while expired
        end
    end

    assign mtime_o     = mtime_q;
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// ==== design/platform_top.sv ====
// Platform top: sliced request and response paths around the decoder and targets
`timescale 1ns/1ps
`default_nettype none

module platform_top (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  bus_pkg::bus_req_t bus_req_i,
    output bus_pkg::bus_rsp_t bus_rsp_o,
    output logic              timer_irq_o,
    output logic              ipi_o
);

    import bus_pkg::*;

    bus_req_t    req_sliced;    // After the request slice
    bus_rsp_t    rsp_merged;    // Before the response slice
    bus_req_t    rom_req;
    bus_req_t    clint_req;
    bus_req_t    ram_req;
    bus_rsp_t    rom_rsp;
    bus_rsp_t    clint_rsp;
    bus_rsp_t    ram_rsp;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    // ----------------------------------------
    // Fabric
    // ----------------------------------------
    bus_slice #(
        .payload_t ( bus_req_t   ),
        .DEPTH     ( SLICE_DEPTH )
    ) i_req_slice (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .d_i        ( bus_req_i  ),
        .q_o        ( req_sliced )
    );

    addr_decoder i_addr_decoder (
        .clk         ( clk        ),
        .ndmreset_n  ( ndmreset_n ),
        .req_i       ( req_sliced ),
        .rsp_o       ( rsp_merged ),
        .rom_req_o   ( rom_req    ),
        .clint_req_o ( clint_req  ),
        .ram_req_o   ( ram_req    ),
        .rom_rsp_i   ( rom_rsp    ),
        .clint_rsp_i ( clint_rsp  ),
        .ram_rsp_i   ( ram_rsp    )
    );

    bus_slice #(
        .payload_t ( bus_rsp_t   ),
        .DEPTH     ( SLICE_DEPTH )
    ) i_rsp_slice (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .d_i        ( rsp_merged ),
        .q_o        ( bus_rsp_o  )
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    boot_rom i_boot_rom (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .req_i      ( rom_req    ),
        .rsp_o      ( rom_rsp    )
    );

    scratch_ram i_scratch_ram (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .req_i      ( ram_req    ),
        .rsp_o      ( ram_rsp    )
    );

    clint_regs i_clint_regs (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .req_i      ( clint_req  ),
        .rsp_o      ( clint_rsp  ),
        .mtime_i    ( mtime      ),
        .mtimecmp_o ( mtimecmp   ),
        .ipi_o      ( ipi_o      )
    );

    clint_timer i_clint_timer (
        .clk         ( clk         ),
        .ndmreset_n  ( ndmreset_n  ),
        .mtimecmp_i  ( mtimecmp    ),
        .mtime_o     ( mtime       ),
        .timer_irq_o ( timer_irq_o )
    );

endmodule

`default_nettype wire

// ==== verif/platform_tb.sv ====
// Platform testbench: drives bus requests, models the targets and checks every response
`timescale 1ns/1ps
`default_nettype none

module platform_tb;

    import bus_pkg::*;
    import soc_map_pkg::*;

    localparam logic [31:0] LATENCY  = 2 * SLICE_DEPTH + 1;
    localparam int          WAIT_MAX = 200;

    typedef struct packed {
        logic [31:0] issue;     // Cycle count when driven
        logic        chk;       // Clear for mtime reads
        bus_rsp_t    rsp;
    } expect_t;

    logic              clk;
    logic              ndmreset_n;
    bus_req_t          bus_req;
    bus_rsp_t          bus_rsp;
    logic              timer_irq;
    logic              ipi;
    logic [DATA_W-1:0] rom_model [8];
    logic [DATA_W-1:0] ram_model [RAM_WORDS];
    logic              msip_model;
    logic [63:0]       mtimecmp_model;
    logic [31:0]       lfsr_q;
    logic [31:0]       cycle_cnt;
    int                fail_cnt;
    int                timeout_cnt;
    expect_t           exp_q [$];
    string             name_q [$];
    logic [63:0]       mtime_seen [$];

    platform_top platform_top_inst (
        .clk         ( clk        ),
        .ndmreset_n  ( ndmreset_n ),
        .bus_req_i   ( bus_req    ),
        .bus_rsp_o   ( bus_rsp    ),
        .timer_irq_o ( timer_irq  ),
        .ipi_o       ( ipi        )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // x^32+x^22+x^2+x+1
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  be);
        logic [63:0] v;
        v = old_word;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                v[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return v;
    endfunction

    // Expected response of one request, updates the model on writes
    function automatic bus_rsp_t expect_rsp(input bus_req_t r, output logic chk);
        bus_rsp_t    e;
        logic [31:0] off;
        e   = '{rvalid: 1'b1, err: 1'b0, rdata: '0};
        chk = 1'b1;
        off = (r.addr - CLINT_BASE) & 32'hffff_fff8;
        if (r.addr >= ROM_BASE && r.addr < ROM_BASE + ROM_LEN) begin
            if (!r.we) begin
                e.rdata = rom_model[r.addr[5:3]];
            end
        end else if (r.addr >= CLINT_BASE && r.addr < CLINT_BASE + CLINT_LEN) begin
            if (r.we) begin
                if (off == 32'(MSIP_OFF) && r.be[0]) begin
                    msip_model = r.wdata[0];
                end
                if (off == 32'(MTIMECMP_OFF)) begin
                    mtimecmp_model = merge_bytes(mtimecmp_model, r.wdata, r.be);
                end
            end else if (off == 32'(MSIP_OFF)) begin
                e.rdata = {63'b0, msip_model};
            end else if (off == 32'(MTIMECMP_OFF)) begin
                e.rdata = mtimecmp_model;
            end else if (off == 32'(MTIME_OFF)) begin
                chk = 1'b0;     // Free running, checked by rate
            end
        end else if (r.addr >= RAM_BASE && r.addr < RAM_BASE + RAM_LEN) begin
            if (r.we) begin
                ram_model[r.addr[10:3]] = merge_bytes(ram_model[r.addr[10:3]], r.wdata, r.be);
            end else begin
                e.rdata = ram_model[r.addr[10:3]];   // 2 KiB alias
            end
        end else begin
            e.err = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [31:0] ram_addr(input logic [7:0] word, input logic [31:0] bank);
        return RAM_BASE + bank + {21'b0, word, 3'b000};
    endfunction

    // ----------------------------------------
    // Bus master tasks
    // ----------------------------------------
    task automatic issue(input string name, input logic we, input logic [31:0] addr,
                         input logic [7:0] be, input logic [63:0] wdata);
        bus_req_t r;
        expect_t  x;
        logic     chk;
        @(negedge clk);
        r       = '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
        bus_req = r;
        x.rsp   = expect_rsp(r, chk);
        x.chk   = chk;
        x.issue = cycle_cnt;
        exp_q.push_back(x);
        name_q.push_back(name);
    endtask

    // Ends a burst and waits for its last response
    task automatic finish_burst(input string what);
        int n;
        @(negedge clk);
        bus_req = '0;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %s burst still waits for %0d responses", what, exp_q.size());
            timeout_cnt++;
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic wait_pin(input string what, input logic use_ipi, input logic val);
        int n;
        n = 0;
        while (((use_ipi ? ipi : timer_irq) !== val) && n < 2) begin
            @(negedge clk);
            n++;
        end
        if ((use_ipi ? ipi : timer_irq) !== val) begin
            $display("Timeout: %s did not reach %b within 2 cycles", what, val);
            timeout_cnt++;
        end
    endtask

    // ----------------------------------------
    // Response checker
    // ----------------------------------------
    always @(negedge clk) begin
        expect_t     x;
        string       name;
        logic [31:0] lat;
        if (ndmreset_n && bus_rsp.rvalid) begin
            if (exp_q.size() == 0) begin
                $display("Error: response arrived with no request outstanding");
                fail_cnt++;
            end else begin
                x    = exp_q.pop_front();
                name = name_q.pop_front();
                lat  = cycle_cnt - x.issue;
                if (lat != LATENCY) begin
                    $display("[FAIL] %s latency: expected %0d, actual %0d", name, LATENCY, lat);
                    fail_cnt++;
                end
                if (bus_rsp.err !== x.rsp.err) begin
                    $display("[FAIL] %s err: expected %b, actual %b", name, x.rsp.err, bus_rsp.err);
                    fail_cnt++;
                end
                if (!x.chk) begin
                    mtime_seen.push_back(bus_rsp.rdata);
                end else if (bus_rsp.rdata !== x.rsp.rdata) begin
                    $display("[FAIL] %s rdata: expected %h, actual %h",
                             name, x.rsp.rdata, bus_rsp.rdata);
                    fail_cnt++;
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [7:0]  idx [4];
        logic [7:0]  be;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [63:0] dt2;
        logic [63:0] k;
        clk            = 1'b0;
        ndmreset_n     = 1'b0;
        bus_req        = '0;
        lfsr_q         = 32'h9b;
        cycle_cnt      = '0;
        fail_cnt       = 0;
        timeout_cnt    = 0;
        msip_model     = 1'b0;
        mtimecmp_model = '1;
        $readmemh("design/boot_rom.hex", rom_model);
        repeat (5) @(posedge clk);
        @(negedge clk);
        ndmreset_n = 1'b1;
        @(negedge clk);
        if (bus_rsp.rvalid !== 1'b0 || timer_irq !== 1'b0 || ipi !== 1'b0) begin
            $display("[FAIL] reset outputs: expected 000, actual %b%b%b",
                     bus_rsp.rvalid, timer_irq, ipi);
            fail_cnt++;
        end

        // ROM image, then a write that must not stick
        for (int i = 0; i < 8; i++) begin
            issue("rom_read", 1'b0, ROM_BASE + 32'(i * 8), '1, '0);
        end
        issue("rom_write", 1'b1, ROM_BASE + 32'h8, 8'hff, rand_bits(64));
        issue("rom_reread", 1'b0, ROM_BASE + 32'h8, '1, '0);
        finish_burst("rom");

        // RAM byte merge on random words
        for (int i = 0; i < 4; i++) begin
            idx[i] = 8'(rand_bits(8));
            be     = 8'(rand_bits(8));
            if (be == 8'h00) begin
                be = 8'h01;
            end
            issue("ram_fill", 1'b1, ram_addr(idx[i], 32'h0), 8'hff, rand_bits(64));
            issue("ram_merge", 1'b1, ram_addr(idx[i], 32'h0), be, rand_bits(64));
            issue("ram_read", 1'b0, ram_addr(idx[i], 32'h0), '1, '0);
        end
        issue("ram_alias_write", 1'b1, ram_addr(idx[0], 32'h800), 8'hff, rand_bits(64));
        issue("ram_alias_read", 1'b0, ram_addr(idx[0], 32'h0), '1, '0);
        finish_burst("ram");

        // Consecutive cycles across every region
        issue("mix_rom", 1'b0, ROM_BASE + 32'h18, '1, '0);
        issue("mix_ram", 1'b0, ram_addr(idx[1], 32'h0), '1, '0);
        issue("mix_clint", 1'b0, CLINT_BASE + 32'(MTIMECMP_OFF), '1, '0);
        issue("mix_none", 1'b0, 32'h4000_0000, '1, '0);
        issue("mix_ram_write", 1'b1, ram_addr(idx[2], 32'h0), 8'h0f, rand_bits(64));
        issue("mix_ram_read", 1'b0, ram_addr(idx[2], 32'h0), '1, '0);
        issue("mix_rom_last", 1'b0, ROM_BASE + 32'h38, '1, '0);
        finish_burst("mixed");

        issue("unmapped_zero", 1'b0, 32'h0000_0000, '1, '0);
        issue("unmapped_top", 1'b1, 32'hffff_fff8, 8'hff, rand_bits(64));
        issue("unmapped_past_rom", 1'b0, ROM_BASE + ROM_LEN, '1, '0);
        finish_burst("unmapped");

        // Timer compare and software interrupt
        issue("mtimecmp_zero", 1'b1, CLINT_BASE + 32'(MTIMECMP_OFF), 8'hff, 64'h0);
        finish_burst("mtimecmp zero");
        wait_pin("timer_irq_o", 1'b0, 1'b1);
        issue("mtimecmp_ones", 1'b1, CLINT_BASE + 32'(MTIMECMP_OFF), 8'hff, '1);
        issue("mtimecmp_read", 1'b0, CLINT_BASE + 32'(MTIMECMP_OFF), '1, '0);
        finish_burst("mtimecmp ones");
        wait_pin("timer_irq_o", 1'b0, 1'b0);
        issue("msip_set", 1'b1, CLINT_BASE + 32'(MSIP_OFF), 8'h01, 64'h1);
        issue("msip_read", 1'b0, CLINT_BASE + 32'(MSIP_OFF), '1, '0);
        finish_burst("msip set");
        wait_pin("ipi_o", 1'b1, 1'b1);
        issue("msip_clear", 1'b1, CLINT_BASE + 32'(MSIP_OFF), 8'h01, 64'h0);
        finish_burst("msip clear");
        wait_pin("ipi_o", 1'b1, 1'b0);

        // mtime rate, half a count per cycle
        mtime_seen.delete();
        issue("mtime_first", 1'b0, CLINT_BASE + 32'(MTIME_OFF), '1, '0);
        t0 = cycle_cnt;
        finish_burst("mtime first");
        repeat (40) @(negedge clk);
        issue("mtime_second", 1'b0, CLINT_BASE + 32'(MTIME_OFF), '1, '0);
        t1 = cycle_cnt;
        finish_burst("mtime second");
        if (mtime_seen.size() != 2) begin
            $display("Error: expected two mtime reads, got %0d", mtime_seen.size());
            fail_cnt++;
        end else begin
            dt2 = (mtime_seen[1] - mtime_seen[0]) << 1;
            k   = {32'b0, t1 - t0};
            if (dt2 + 64'd2 < k || dt2 > k + 64'd2) begin
                $display("[FAIL] mtime_rate: expected %0d, actual %0d", k >> 1, dt2 >> 1);
                fail_cnt++;
            end
        end

        $display("Errors: %0d check failures, %0d timeouts", fail_cnt, timeout_cnt);
        if (fail_cnt == 0 && timeout_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/boot_rom.hex ====
// Boot ROM image, one 64-bit word per line in hex, word 0 at the top
00000297_02028593
f1402573_0182b283
00028067_0000006f
10500073_ffdff06f
80000537_00050513
deadbeef_cafef00d
0123456789abcdef
a5a55a5a_c3c33c3c

// ==== platform_top.f ====
design/bus_pkg.sv
design/soc_map_pkg.sv
design/bus_slice.sv
design/addr_decoder.sv
design/boot_rom.sv
design/scratch_ram.sv
design/clint_regs.sv
design/clint_timer.sv
design/platform_top.sv
verif/platform_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the platform testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f platform_top.f --top-module platform_tb \
    --Mdir obj_dir -o platform_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/platform_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1
